// File: verilog/neighbor_pkg.sv
package neighbor_pkg;

    // ============================================================
    // sizes
    // ============================================================
    localparam int NUM_BANKS   = 4;
    localparam int BANK_SEL_W  = 2;     // top address bits pick the bank
    localparam int BANK_ADDR_W = 8;
    localparam int ADDR_W      = BANK_SEL_W + BANK_ADDR_W;
    localparam int TAG_W       = 4;
    localparam int DATA_W      = 16;    // one neighbor identifier

    // ============================================================
    // types
    // ============================================================
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } neighbor_op_t;

    // request as it comes from a PE
    typedef struct packed {
        neighbor_op_t        op;
        logic [TAG_W-1:0]    pe_tag;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
    } neighbor_req_t;

    // request after routing carries only the address inside the bank
    typedef struct packed {
        logic                   valid;
        neighbor_op_t           op;
        logic [TAG_W-1:0]       pe_tag;
        logic [BANK_ADDR_W-1:0] bank_addr;
        logic [DATA_W-1:0]      wdata;
    } bank_req_t;

    typedef struct packed {
        logic [TAG_W-1:0]      pe_tag;
        logic [BANK_SEL_W-1:0] bank;
        logic [DATA_W-1:0]     rdata;   // for a write this echoes wdata
    } neighbor_resp_t;

endpackage

// File: verilog/neighbor_req_fifo.sv
module neighbor_req_fifo import neighbor_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          req_valid,
    input  neighbor_req_t req,
    input  logic          pop,
    output logic          empty,
    output neighbor_req_t head,
    output logic          head_valid,
    output logic          credit_return
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    neighbor_req_t    mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_pop;

    assign empty  = (count == '0);
    assign do_pop = pop && !empty;

    // the sender pushes only while it holds a credit
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            head_valid    <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two so the pointer wraps
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({req_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            head_valid    <= do_pop;
            credit_return <= do_pop;    // the freed slot goes back to the sender
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= req;
        end
        if (do_pop) begin
            head <= mem[rd_ptr];
        end
    end

endmodule

// File: verilog/neighbor_dispatch.sv
module neighbor_dispatch import neighbor_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       empty,
    input  neighbor_req_t              head,
    input  logic                       head_valid,
    input  logic [NUM_BANKS-1:0]       bank_busy,
    output logic                       pop,
    output bank_req_t [NUM_BANKS-1:0]  bank_req
);

    typedef enum logic [1:0] {
        st_idle     = 2'd0,
        st_route    = 2'd1,
        st_stall    = 2'd2,
        st_complete = 2'd3
    } state_t;

    state_t                    state;
    state_t                    nx_state;
    logic                      nx_pop;
    bank_req_t [NUM_BANKS-1:0] nx_bank_req;
    neighbor_req_t             held;
    logic [BANK_SEL_W-1:0]     head_bank;
    logic [BANK_SEL_W-1:0]     held_bank;

    assign head_bank = head.addr[ADDR_W-1 -: BANK_SEL_W];
    assign held_bank = held.addr[ADDR_W-1 -: BANK_SEL_W];

    function automatic bank_req_t to_bank(neighbor_req_t r);
        bank_req_t b;
        b.valid     = 1'b1;
        b.op        = r.op;
        b.pe_tag    = r.pe_tag;
        b.bank_addr = r.addr[BANK_ADDR_W-1:0];
        b.wdata     = r.wdata;
        return b;
    endfunction

    // ============================================================
    // next state
    // ============================================================
    always_comb begin
        nx_state    = state;
        nx_pop      = 1'b0;
        nx_bank_req = '0;
        case (state)
            st_idle: begin
                if (!empty) begin
                    nx_pop   = 1'b1;
                    nx_state = st_route;
                end
            end
            st_route: begin
                if (head_valid) begin
                    if (bank_busy[head_bank]) begin
                        nx_state = st_stall;
                    end else begin
                        nx_bank_req[head_bank] = to_bank(head);
                        nx_pop   = !empty;      // fetch the next one while this one issues
                        nx_state = st_complete;
                    end
                end
            end
            st_stall: begin
                if (!bank_busy[held_bank]) begin
                    nx_bank_req[held_bank] = to_bank(held);
                    nx_pop   = !empty;
                    nx_state = st_complete;
                end
            end
            st_complete: begin
                // bank request is on the wire this cycle
                if (pop) begin
                    nx_state = st_route;
                end else if (!empty) begin
                    nx_pop   = 1'b1;
                    nx_state = st_route;
                end else begin
                    nx_state = st_idle;
                end
            end
            default: nx_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            pop      <= 1'b0;
            bank_req <= '0;
        end else begin
            state    <= nx_state;
            pop      <= nx_pop;
            bank_req <= nx_bank_req;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_route && head_valid) begin
            held <= head;   // kept for the stall path
        end
    end

endmodule

// File: verilog/neighbor_bank_ctrl.sv
module neighbor_bank_ctrl import neighbor_pkg::*; #(
    parameter int BANK_LATENCY = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [BANK_SEL_W-1:0] bank_id,
    input  bank_req_t             bank_req,
    input  logic                  grant,
    output logic                  busy,
    output logic                  resp_valid,
    output neighbor_resp_t        resp
);

    localparam int CNT_W = $clog2(BANK_LATENCY + 1);

    logic [DATA_W-1:0] mem [2**BANK_ADDR_W];
    logic [CNT_W-1:0]  lat_cnt;
    logic              accept;

    assign accept = bank_req.valid && !busy;

    // ============================================================
    // busy and latency control
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            resp_valid <= 1'b0;
            lat_cnt    <= '0;
        end else begin
            if (accept) begin
                busy    <= 1'b1;
                lat_cnt <= CNT_W'(BANK_LATENCY);
            end else if (busy && !resp_valid) begin
                lat_cnt <= lat_cnt - 1'b1;
                if (lat_cnt == CNT_W'(1)) begin
                    resp_valid <= 1'b1;     // last latency cycle
                end
            end else if (resp_valid && grant) begin
                resp_valid <= 1'b0;
                busy       <= 1'b0;     // bank opens again one cycle after the grant
            end
        end
    end

    // ============================================================
    // memory access and held response
    // ============================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            if (bank_req.op == op_write) begin
                mem[bank_req.bank_addr] <= bank_req.wdata;
                resp.rdata              <= bank_req.wdata;
            end else begin
                resp.rdata <= mem[bank_req.bank_addr];
            end
            resp.pe_tag <= bank_req.pe_tag;
            resp.bank   <= bank_id;     // request carries no bank bits any more
        end
    end

endmodule

// File: verilog/neighbor_resp_merge.sv
module neighbor_resp_merge import neighbor_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [NUM_BANKS-1:0]            resp_valid,
    input  neighbor_resp_t [NUM_BANKS-1:0]  resp,
    output logic [NUM_BANKS-1:0]            grant,
    output logic                            out_valid,
    output neighbor_resp_t                  out_resp
);

    logic [BANK_SEL_W-1:0] rr_ptr;
    logic [BANK_SEL_W-1:0] winner;
    logic                  found;

    // search starts at rr_ptr and takes the first bank holding a response
    always_comb begin
        logic [BANK_SEL_W-1:0] idx;
        winner = rr_ptr;
        found  = 1'b0;
        grant  = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            idx = rr_ptr + BANK_SEL_W'(i);
            if (!found && resp_valid[idx]) begin
                found  = 1'b1;
                winner = idx;
            end
        end
        if (found) begin
            grant[winner] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= found;
            if (found) begin
                rr_ptr <= winner + 1'b1;    // winner drops to lowest priority
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            out_resp <= resp[winner];
        end
    end

endmodule

// File: verilog/neighbor_fetch_top.sv
module neighbor_fetch_top import neighbor_pkg::*; #(
    parameter int FIFO_DEPTH   = 8,
    parameter int BANK_LATENCY = 2
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           req_valid,
    input  neighbor_req_t  req,
    output logic           credit_return,
    output logic           out_valid,
    output neighbor_resp_t out_resp
);

    logic                           fifo_empty;
    logic                           fifo_pop;
    neighbor_req_t                  fifo_head;
    logic                           head_valid;
    logic [NUM_BANKS-1:0]           bank_busy;
    bank_req_t [NUM_BANKS-1:0]      bank_req;
    logic [NUM_BANKS-1:0]           resp_valid;
    neighbor_resp_t [NUM_BANKS-1:0] bank_resp;
    logic [NUM_BANKS-1:0]           grant;

    neighbor_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .pop           (fifo_pop),
        .empty         (fifo_empty),
        .head          (fifo_head),
        .head_valid    (head_valid),
        .credit_return (credit_return)
    );

    neighbor_dispatch u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .empty      (fifo_empty),
        .head       (fifo_head),
        .head_valid (head_valid),
        .bank_busy  (bank_busy),
        .pop        (fifo_pop),
        .bank_req   (bank_req)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        neighbor_bank_ctrl #(.BANK_LATENCY(BANK_LATENCY)) u_bank (
            .clk        (clk),
            .reset      (reset),
            .bank_id    (BANK_SEL_W'(i)),
            .bank_req   (bank_req[i]),
            .grant      (grant[i]),
            .busy       (bank_busy[i]),
            .resp_valid (resp_valid[i]),
            .resp       (bank_resp[i])
        );
    end

    neighbor_resp_merge u_merge (
        .clk        (clk),
        .reset      (reset),
        .resp_valid (resp_valid),
        .resp       (bank_resp),
        .grant      (grant),
        .out_valid  (out_valid),
        .out_resp   (out_resp)
    );

endmodule

// File: verification/neighbor_fetch_tb.sv
module neighbor_fetch_tb import neighbor_pkg::*; ();

    localparam int FIFO_DEPTH     = 8;
    localparam int BANK_LATENCY   = 2;
    localparam int NUM_ROWS       = 16;
    localparam int NUM_RANDOM     = 60;
    localparam int CREDIT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 2000;

    typedef struct packed {
        neighbor_op_t      op;
        logic [TAG_W-1:0]  pe_tag;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [3:0]        gap;     // idle cycles after the row
    } stim_row_t;

    logic           clk = 1'b0;
    logic           reset;
    logic           req_valid;
    neighbor_req_t  req;
    logic           credit_return;
    logic           out_valid;
    neighbor_resp_t out_resp;

    stim_row_t         rows [NUM_ROWS];
    logic [DATA_W-1:0] ref_mem [2**ADDR_W];
    logic              written [2**ADDR_W];
    neighbor_resp_t    expect_q [NUM_BANKS][$];
    logic [31:0]       lfsr;
    int                credits;
    int                returns;
    int                sent_count = 0;
    int                resp_count = 0;
    int                error_count = 0;
    int                timeout_count = 0;

    neighbor_fetch_top #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .BANK_LATENCY (BANK_LATENCY)
    ) UUT (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_resp      (out_resp)
    );

    always #50 clk = ~clk;

    // ============================================================
    // helpers
    // ============================================================
    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d timeouts, %0d of %0d responses seen",
                 error_count, timeout_count, resp_count, sent_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            n += expect_q[b].size();
        end
        return n;
    endfunction

    // sender credit count where each request is charged at the edge the DUT samples it
    always @(posedge clk) begin
        if (reset) begin
            credits <= FIFO_DEPTH;
            returns <= 0;
        end else begin
            credits <= credits + int'(credit_return) - int'(req_valid);
            returns <= returns + int'(credit_return);
        end
    end

    task automatic send_req(stim_row_t r);
        neighbor_req_t         n;
        neighbor_resp_t        e;
        logic [BANK_SEL_W-1:0] b;
        int                    waited;
        waited = 0;
        @(posedge clk);
        while (credits - int'(req_valid) <= 0 && waited < CREDIT_TIMEOUT) begin
            waited++;
            req_valid <= 1'b0;
            @(posedge clk);
        end
        if (credits - int'(req_valid) <= 0) begin
            timeout_count++;
            $display("no credit came back within %0d cycles, the request queue is stuck",
                     CREDIT_TIMEOUT);
            finish_run();
        end else begin
            n.op      = r.op;
            n.pe_tag  = r.pe_tag;
            n.addr    = r.addr;
            n.wdata   = r.wdata;
            req_valid <= 1'b1;
            req       <= n;
            // reference model sees requests in send order, which each bank keeps
            b        = r.addr[ADDR_W-1 -: BANK_SEL_W];
            e.pe_tag = r.pe_tag;
            e.bank   = b;
            if (r.op == op_write) begin
                ref_mem[r.addr] = r.wdata;
                written[r.addr] = 1'b1;
                e.rdata         = r.wdata;
            end else begin
                e.rdata = ref_mem[r.addr];
            end
            expect_q[b].push_back(e);
            sent_count++;
        end
    endtask

    task automatic apply_row(stim_row_t r);
        send_req(r);
        repeat (r.gap) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk);
        req_valid <= 1'b0;
        while (outstanding() != 0 && waited < DRAIN_TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (outstanding() != 0) begin
            timeout_count++;
            $display("%0d responses never came out of the DUT", outstanding());
            finish_run();
        end
    endtask

    task automatic check_response();
        neighbor_resp_t e;
        int             b;
        b = int'(out_resp.bank);
        resp_count++;
        if (expect_q[b].size() == 0) begin
            error_count++;
            $display("response with tag %0h came from bank %0d, which had nothing outstanding",
                     out_resp.pe_tag, b);
        end else begin
            e = expect_q[b].pop_front();
            check_value("response tag", 32'(out_resp.pe_tag), 32'(e.pe_tag));
            check_value("response data", 32'(out_resp.rdata), 32'(e.rdata));
        end
    endtask

    always @(posedge clk) begin
        if (!reset && out_valid) begin
            check_response();
        end
    end

    // ============================================================
    // stimulus
    // ============================================================
    initial begin
        stim_row_t r;
        int        base;
        rows = '{
            '{op_write, 4'h1, 10'h105, 16'hbeef, 4'd3},     // write then read back
            '{op_read,  4'h2, 10'h105, 16'h0000, 4'd2},
            '{op_write, 4'h3, 10'h011, 16'h1111, 4'd0},     // one per bank
            '{op_write, 4'h4, 10'h122, 16'h2222, 4'd0},
            '{op_write, 4'h5, 10'h233, 16'h3333, 4'd0},
            '{op_write, 4'h6, 10'h344, 16'h4444, 4'd0},
            '{op_read,  4'h7, 10'h344, 16'h0000, 4'd0},
            '{op_read,  4'h8, 10'h233, 16'h0000, 4'd0},
            '{op_read,  4'h9, 10'h122, 16'h0000, 4'd0},
            '{op_read,  4'ha, 10'h011, 16'h0000, 4'd1},
            '{op_write, 4'hb, 10'h2a0, 16'h0a0a, 4'd0},     // bank 2 back to back
            '{op_write, 4'hc, 10'h2a1, 16'h0b0b, 4'd0},
            '{op_read,  4'hd, 10'h2a0, 16'h0000, 4'd0},
            '{op_read,  4'he, 10'h2a1, 16'h0000, 4'd0},
            '{op_write, 4'hf, 10'h2a0, 16'hc0de, 4'd0},
            '{op_read,  4'h0, 10'h2a0, 16'h0000, 4'd0}
        };
        for (int i = 0; i < 2**ADDR_W; i++) begin
            written[i] = 1'b0;
        end
        lfsr      = 32'h90348d5d;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // quiet outputs before the first request
        repeat (6) begin
            @(posedge clk);
            check_value("credit_return before traffic", 32'(credit_return), 32'd0);
            check_value("out_valid before traffic", 32'(out_valid), 32'd0);
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i]);
        end
        wait_drain();

        // burst of a full queue worth of reads to one bank
        base = returns;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            r.op     = op_read;
            r.pe_tag = TAG_W'(i);
            r.addr   = 10'h344;
            r.wdata  = '0;
            r.gap    = '0;
            apply_row(r);
        end
        wait_drain();
        check_value("credit returns in burst", returns - base, FIFO_DEPTH);
        check_value("credits after burst", credits, FIFO_DEPTH);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            r.op     = neighbor_op_t'(rand_bits(1));
            r.pe_tag = TAG_W'(rand_bits(TAG_W));
            r.addr   = ADDR_W'(rand_bits(ADDR_W));
            r.wdata  = DATA_W'(rand_bits(DATA_W));
            r.gap    = 4'(rand_bits(2));
            if (r.op == op_read && !written[r.addr]) begin
                r.op = op_write;    // unwritten words hold no defined value
            end
            apply_row(r);
        end
        wait_drain();

        repeat (10) @(posedge clk);
        check_value("responses received", resp_count, sent_count);
        check_value("credits at the end", credits, FIFO_DEPTH);
        finish_run();
    end

endmodule

// File: flist.f
verilog/neighbor_pkg.sv
verilog/neighbor_req_fifo.sv
verilog/neighbor_dispatch.sv
verilog/neighbor_bank_ctrl.sv
verilog/neighbor_resp_merge.sv
verilog/neighbor_fetch_top.sv
verification/neighbor_fetch_tb.sv

// File: Makefile
# Verilator build and run for the neighbor fetch testbench

VERILATOR ?= verilator
TOP       ?= neighbor_fetch_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
